// File: src/xt_bus_pkg.sv
package xt_bus_pkg;

	localparam int CPU_ADDR_BITS = 20;
	localparam int SRAM_ADDR_BITS = CPU_ADDR_BITS + 1;
	localparam int BUS_BYTE_BITS = 8;
	localparam int IO_PORT_BITS = 16;
	localparam int SEGMENT_BITS = 4;
	localparam int EMS_PAGE_BITS = 6;
	localparam int EMS_SLOTS = 4;
	localparam int EMS_MAP_BITS = EMS_SLOTS * EMS_PAGE_BITS;

	// 16 KB per EMS window
	localparam int WINDOW_OFFSET_BITS = 14;

	typedef logic [CPU_ADDR_BITS-1:0] cpu_addr_t;
	// bit 20 set means an expanded-memory page
	typedef logic [SRAM_ADDR_BITS-1:0] sram_addr_t;
	typedef logic [BUS_BYTE_BITS-1:0] bus_byte_t;
	typedef logic [IO_PORT_BITS-1:0] io_port_t;
	typedef logic [SEGMENT_BITS-1:0] segment_t;
	typedef logic [EMS_PAGE_BITS-1:0] ems_page_t;
	typedef logic [$clog2(EMS_SLOTS)-1:0] ems_slot_t;
	typedef logic [EMS_MAP_BITS-1:0] ems_map_t;
	typedef logic [EMS_SLOTS-1:0] ems_enable_t;

	// four consecutive ports, one per slot
	localparam io_port_t EMS_PORT_BASE = 16'h0260;
	localparam io_port_t LPT_PORT = 16'h0378;

	localparam bus_byte_t EMS_DISABLE_CODE = 8'hff;
	// bytes below this map a page
	localparam bus_byte_t EMS_MAP_LIMIT = 8'h80;
	localparam ems_page_t EMS_PAGE_DISABLED = 6'h3f;
	localparam bus_byte_t UNMAPPED_READ = 8'hff;

	// window bases for base select 0, 1 and the rest
	localparam segment_t EMS_SEGMENT_C = 4'hc;
	localparam segment_t EMS_SEGMENT_D = 4'hd;
	localparam segment_t EMS_SEGMENT_E = 4'he;

	// printer latch idles high
	localparam bus_byte_t LPT_RESET_VALUE = 8'hff;

endpackage

// File: src/io_port_decoder.sv
`timescale 1ns/1ps

module io_port_decoder (
	input  xt_bus_pkg::cpu_addr_t address_i,
	input  logic                  io_read_n_i,
	input  logic                  io_write_n_i,
	input  logic                  address_enable_n_i,
	input  logic                  ems_enabled_i,
	output logic                  ems_port_sel_o,
	output logic                  lpt_sel_o,
	output logic                  sram_sel_o
);

	import xt_bus_pkg::*;

	io_port_t io_port;
	logic io_cycle;
	logic cpu_cycle;
	logic ems_port_hit;
	logic lpt_port_hit;

	// only the low 16 bits carry an I/O port
	assign io_port = address_i[IO_PORT_BITS-1:0];

	// either strobe low makes it an I/O cycle
	assign io_cycle = ~io_read_n_i | ~io_write_n_i;

	// AEN high means DMA owns the bus
	assign cpu_cycle = ~address_enable_n_i;

	// low two bits pick the slot, so ignore them here
	assign ems_port_hit = (io_port[IO_PORT_BITS-1:2] == EMS_PORT_BASE[IO_PORT_BITS-1:2]);
	assign lpt_port_hit = (io_port == LPT_PORT);

	assign ems_port_sel_o = io_cycle & cpu_cycle & ems_enabled_i & ems_port_hit;
	assign lpt_sel_o = io_cycle & cpu_cycle & lpt_port_hit;

	// any memory cycle from the CPU lands in SRAM
	assign sram_sel_o = ~io_cycle & cpu_cycle;

endmodule

// File: src/ems_page_registers.sv
`timescale 1ns/1ps

module ems_page_registers (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    ems_port_sel_i,
	input  logic                    io_write_n_i,
	input  xt_bus_pkg::ems_slot_t   slot_i,
	input  xt_bus_pkg::bus_byte_t   data_i,
	output xt_bus_pkg::ems_map_t    page_map_o,
	output xt_bus_pkg::ems_enable_t slot_enable_o,
	output xt_bus_pkg::bus_byte_t   read_byte_o
);

	import xt_bus_pkg::*;

	ems_page_t page_q [EMS_SLOTS];
	ems_enable_t enable_q;

	logic write_req;
	ems_page_t cur_page;
	logic cur_enable;
	ems_page_t next_page;
	logic next_enable;

	logic stage_write_q;
	ems_slot_t stage_slot_q;
	ems_page_t stage_page_q;
	logic stage_enable_q;

	assign write_req = ems_port_sel_i & ~io_write_n_i;

	// a staged write to the same slot is newer than the register
	always_comb begin
		if (stage_write_q && (stage_slot_q == slot_i)) begin
			cur_page = stage_page_q;
			cur_enable = stage_enable_q;
		end else begin
			cur_page = page_q[slot_i];
			cur_enable = enable_q[slot_i];
		end
	end

	// disable, map, or keep the old entry
	always_comb begin
		if (data_i == EMS_DISABLE_CODE) begin
			next_page = EMS_PAGE_DISABLED;
			next_enable = 1'b0;
		end else if (data_i < EMS_MAP_LIMIT) begin
			next_page = data_i[EMS_PAGE_BITS-1:0];
			next_enable = 1'b1;
		end else begin
			next_page = cur_page;
			next_enable = cur_enable;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			stage_write_q <= 1'b0;
		end else begin
			stage_write_q <= write_req;
		end
	end

	always_ff @(posedge clock) begin
		stage_slot_q <= slot_i;
		stage_page_q <= next_page;
		stage_enable_q <= next_enable;
	end

	// second edge commits the staged entry
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < EMS_SLOTS; i++) begin
				page_q[i] <= '0;
			end
			enable_q <= '0;
		end else if (stage_write_q) begin
			page_q[stage_slot_q] <= stage_page_q;
			enable_q[stage_slot_q] <= stage_enable_q;
		end
	end

	// slot 0 sits in the top bits of the map
	for (genvar i = 0; i < EMS_SLOTS; i++) begin : g_pack
		assign page_map_o[(EMS_SLOTS-1-i)*EMS_PAGE_BITS +: EMS_PAGE_BITS] = page_q[i];
	end

	assign slot_enable_o = enable_q;

	assign read_byte_o = enable_q[slot_i] ?
		{{(BUS_BYTE_BITS-EMS_PAGE_BITS){1'b0}}, page_q[slot_i]} : UNMAPPED_READ;

endmodule

// File: src/ems_address_mapper.sv
`timescale 1ns/1ps

module ems_address_mapper (
	input  xt_bus_pkg::cpu_addr_t   address_i,
	input  logic [1:0]              ems_base_select_i,
	input  xt_bus_pkg::ems_map_t    page_map_i,
	input  xt_bus_pkg::ems_enable_t slot_enable_i,
	input  logic                    sram_sel_i,
	input  logic                    memory_write_n_i,
	output xt_bus_pkg::sram_addr_t  sram_addr_o,
	output logic                    sram_we_n_o
);

	import xt_bus_pkg::*;

	segment_t segment;
	ems_enable_t slot_hit;
	ems_page_t hit_page;
	logic window_hit;

	always_comb begin
		case (ems_base_select_i)
			2'd0: segment = EMS_SEGMENT_C;
			2'd1: segment = EMS_SEGMENT_D;
			default: segment = EMS_SEGMENT_E;
		endcase
	end

	// 64 KB segment split into four 16 KB windows
	for (genvar k = 0; k < EMS_SLOTS; k++) begin : g_match
		assign slot_hit[k] = slot_enable_i[k] &&
			(address_i[CPU_ADDR_BITS-1:WINDOW_OFFSET_BITS] == {segment, ems_slot_t'(k)});
	end

	assign window_hit = |slot_hit;

	// at most one slot can match
	always_comb begin
		hit_page = '0;
		for (int k = 0; k < EMS_SLOTS; k++) begin
			if (slot_hit[k]) begin
				hit_page = page_map_i[(EMS_SLOTS-1-k)*EMS_PAGE_BITS +: EMS_PAGE_BITS];
			end
		end
	end

	assign sram_addr_o = window_hit ?
		{1'b1, hit_page, address_i[WINDOW_OFFSET_BITS-1:0]} : {1'b0, address_i};

	assign sram_we_n_o = ~(sram_sel_i & ~memory_write_n_i);

endmodule

// File: src/chipset_bus_port.sv
`timescale 1ns/1ps

module chipset_bus_port (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  io_read_n_i,
	input  logic                  io_write_n_i,
	input  logic                  memory_read_n_i,
	input  logic                  ems_port_sel_i,
	input  logic                  lpt_sel_i,
	input  logic                  sram_sel_i,
	input  xt_bus_pkg::bus_byte_t data_i,
	input  xt_bus_pkg::bus_byte_t ems_read_byte_i,
	input  xt_bus_pkg::bus_byte_t sram_data_i,
	output xt_bus_pkg::bus_byte_t data_o,
	output logic                  data_valid_o,
	output xt_bus_pkg::bus_byte_t lpt_data_o
);

	import xt_bus_pkg::*;

	bus_byte_t lpt_q;
	bus_byte_t read_data;
	logic read_valid;
	logic ems_read;
	logic lpt_read;
	logic sram_read;
	logic lpt_write;

	assign ems_read = ems_port_sel_i & ~io_read_n_i;
	assign lpt_read = lpt_sel_i & ~io_read_n_i;
	assign sram_read = sram_sel_i & ~memory_read_n_i;
	assign lpt_write = lpt_sel_i & ~io_write_n_i;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_q <= LPT_RESET_VALUE;
		end else if (lpt_write) begin
			lpt_q <= data_i;
		end
	end

	// EMS ports first, then printer, then SRAM
	always_comb begin
		read_valid = 1'b1;
		if (ems_read) begin
			read_data = ems_read_byte_i;
		end else if (lpt_read) begin
			read_data = lpt_q;
		end else if (sram_read) begin
			read_data = sram_data_i;
		end else begin
			read_valid = 1'b0;
			read_data = '0;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_o <= '0;
			data_valid_o <= 1'b0;
		end else begin
			data_o <= read_data;
			data_valid_o <= read_valid;
		end
	end

	assign lpt_data_o = lpt_q;

endmodule

// File: src/xt_memory_chipset.sv
`timescale 1ns/1ps

module xt_memory_chipset (
	input  logic                   clock,
	input  logic                   reset,
	input  xt_bus_pkg::cpu_addr_t  address_i,
	input  xt_bus_pkg::bus_byte_t  data_i,
	input  logic                   io_read_n_i,
	input  logic                   io_write_n_i,
	input  logic                   memory_read_n_i,
	input  logic                   memory_write_n_i,
	input  logic                   address_enable_n_i,
	input  logic                   ems_enabled_i,
	input  logic [1:0]             ems_base_select_i,
	input  xt_bus_pkg::bus_byte_t  sram_data_i,
	output xt_bus_pkg::bus_byte_t  data_o,
	output logic                   data_valid_o,
	output xt_bus_pkg::sram_addr_t sram_addr_o,
	output logic                   sram_we_n_o,
	output xt_bus_pkg::bus_byte_t  lpt_data_o
);

	import xt_bus_pkg::*;

	logic ems_port_sel;
	logic lpt_sel;
	logic sram_sel;
	ems_map_t ems_page_map;
	ems_enable_t ems_slot_enable;
	bus_byte_t ems_read_byte;

	io_port_decoder io_port_decoder_inst (
		.address_i          (address_i),
		.io_read_n_i        (io_read_n_i),
		.io_write_n_i       (io_write_n_i),
		.address_enable_n_i (address_enable_n_i),
		.ems_enabled_i      (ems_enabled_i),
		.ems_port_sel_o     (ems_port_sel),
		.lpt_sel_o          (lpt_sel),
		.sram_sel_o         (sram_sel)
	);

	// slot index comes straight from the port address
	ems_page_registers ems_page_registers_inst (
		.clock          (clock),
		.reset          (reset),
		.ems_port_sel_i (ems_port_sel),
		.io_write_n_i   (io_write_n_i),
		.slot_i         (address_i[$bits(ems_slot_t)-1:0]),
		.data_i         (data_i),
		.page_map_o     (ems_page_map),
		.slot_enable_o  (ems_slot_enable),
		.read_byte_o    (ems_read_byte)
	);

	ems_address_mapper ems_address_mapper_inst (
		.address_i         (address_i),
		.ems_base_select_i (ems_base_select_i),
		.page_map_i        (ems_page_map),
		.slot_enable_i     (ems_slot_enable),
		.sram_sel_i        (sram_sel),
		.memory_write_n_i  (memory_write_n_i),
		.sram_addr_o       (sram_addr_o),
		.sram_we_n_o       (sram_we_n_o)
	);

	chipset_bus_port chipset_bus_port_inst (
		.clock           (clock),
		.reset           (reset),
		.io_read_n_i     (io_read_n_i),
		.io_write_n_i    (io_write_n_i),
		.memory_read_n_i (memory_read_n_i),
		.ems_port_sel_i  (ems_port_sel),
		.lpt_sel_i       (lpt_sel),
		.sram_sel_i      (sram_sel),
		.data_i          (data_i),
		.ems_read_byte_i (ems_read_byte),
		.sram_data_i     (sram_data_i),
		.data_o          (data_o),
		.data_valid_o    (data_valid_o),
		.lpt_data_o      (lpt_data_o)
	);

endmodule

// File: sim/xt_memory_chipset_checker.sv
`timescale 1ns/1ps

module xt_memory_chipset_checker (
	input logic                  clock,
	input logic                  reset,
	input xt_bus_pkg::bus_byte_t data_i,
	input logic                  data_valid_i,
	input logic                  sram_we_n_i,
	input logic                  io_read_n_i,
	input logic                  io_write_n_i
);

	int error_count = 0;

	// bus parks at zero between reads
	idle_bus_zero: assert property (@(posedge clock) disable iff (reset)
		!data_valid_i |-> data_i == '0)
	else begin
		$error("data bus not zero while data_valid is low");
		error_count++;
	end

	// I/O cycles never touch SRAM
	no_sram_write_in_io: assert property (@(posedge clock) disable iff (reset)
		(!io_read_n_i || !io_write_n_i) |-> sram_we_n_i)
	else begin
		$error("SRAM write strobe active during an I/O cycle");
		error_count++;
	end

	// first edge out of reset
	valid_low_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !data_valid_i)
	else begin
		$error("data_valid high on the first cycle after reset");
		error_count++;
	end

endmodule

// File: sim/tb_xt_memory_chipset.sv
`timescale 1ns/1ps

module tb_xt_memory_chipset;

	import xt_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;
	// active-low strobe order is io read, io write, memory read, memory write
	localparam logic [3:0] IDLE = 4'b1111;
	localparam logic [3:0] IO_READ = 4'b0111;
	localparam logic [3:0] IO_WRITE = 4'b1011;
	localparam logic [3:0] MEM_READ = 4'b1101;
	localparam logic [3:0] MEM_WRITE = 4'b1110;

	logic clock = 1'b0;
	logic reset;
	cpu_addr_t address;
	bus_byte_t data;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic memory_write_n;
	logic address_enable_n;
	logic ems_enabled;
	logic [1:0] ems_base_select;
	bus_byte_t sram_data;
	bus_byte_t data_out;
	logic data_valid;
	sram_addr_t sram_addr;
	logic sram_we_n;
	bus_byte_t lpt_data;

	logic [31:0] seed = 32'he8f139f6;
	int cycle_count = 0;

	// shown_* trails model_* by one edge like the committed page registers
	logic [EMS_SLOTS-1:0][EMS_PAGE_BITS-1:0] model_page;
	logic [EMS_SLOTS-1:0][EMS_PAGE_BITS-1:0] shown_page;
	logic [EMS_SLOTS-1:0] model_enable;
	logic [EMS_SLOTS-1:0] shown_enable;
	bus_byte_t model_lpt;
	bus_byte_t exp_data;
	logic exp_valid;
	sram_addr_t exp_sram_addr;
	segment_t exp_segment;
	logic io_cycle;
	logic ems_sel;
	logic lpt_sel;
	logic mem_sel;
	ems_slot_t port_slot;

	xt_memory_chipset xt_memory_chipset_inst (
		.clock              (clock),
		.reset              (reset),
		.address_i          (address),
		.data_i             (data),
		.io_read_n_i        (io_read_n),
		.io_write_n_i       (io_write_n),
		.memory_read_n_i    (memory_read_n),
		.memory_write_n_i   (memory_write_n),
		.address_enable_n_i (address_enable_n),
		.ems_enabled_i      (ems_enabled),
		.ems_base_select_i  (ems_base_select),
		.sram_data_i        (sram_data),
		.data_o             (data_out),
		.data_valid_o       (data_valid),
		.sram_addr_o        (sram_addr),
		.sram_we_n_o        (sram_we_n),
		.lpt_data_o         (lpt_data)
	);

	bind xt_memory_chipset xt_memory_chipset_checker xt_memory_chipset_checker_inst (
		.clock        (clock),
		.reset        (reset),
		.data_i       (data_o),
		.data_valid_i (data_valid_o),
		.sram_we_n_i  (sram_we_n_o),
		.io_read_n_i  (io_read_n_i),
		.io_write_n_i (io_write_n_i)
	);

	always #20 clock = ~clock;

	assign io_cycle = !io_read_n || !io_write_n;
	assign ems_sel = io_cycle && !address_enable_n && ems_enabled &&
		(address[15:2] == EMS_PORT_BASE[15:2]);
	assign lpt_sel = io_cycle && !address_enable_n && (address[15:0] == LPT_PORT);
	assign mem_sel = !io_cycle && !address_enable_n;
	assign port_slot = address[1:0];

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			model_page <= '0;
			shown_page <= '0;
			model_enable <= '0;
			shown_enable <= '0;
			model_lpt <= 8'hff;
			exp_data <= '0;
			exp_valid <= 1'b0;
		end else begin
			shown_page <= model_page;
			shown_enable <= model_enable;
			// bytes 80..fe leave the slot alone
			if (ems_sel && !io_write_n) begin
				if (data == EMS_DISABLE_CODE) begin
					model_page[port_slot] <= 6'h3f;
					model_enable[port_slot] <= 1'b0;
				end else if (data < EMS_MAP_LIMIT) begin
					model_page[port_slot] <= data[EMS_PAGE_BITS-1:0];
					model_enable[port_slot] <= 1'b1;
				end
			end
			if (lpt_sel && !io_write_n) begin
				model_lpt <= data;
			end
			exp_valid <= 1'b1;
			if (ems_sel && !io_read_n) begin
				exp_data <= shown_enable[port_slot] ?
					{2'b00, shown_page[port_slot]} : UNMAPPED_READ;
			end else if (lpt_sel && !io_read_n) begin
				exp_data <= model_lpt;
			end else if (mem_sel && !memory_read_n) begin
				exp_data <= sram_data;
			end else begin
				exp_valid <= 1'b0;
				exp_data <= '0;
			end
		end
	end

	always_comb begin
		exp_segment = (ems_base_select == 2'd0) ? 4'hc : (ems_base_select == 2'd1) ? 4'hd : 4'he;
		exp_sram_addr = {1'b0, address};
		if (address[19:16] == exp_segment && shown_enable[address[15:14]]) begin
			exp_sram_addr = {1'b1, shown_page[address[15:14]], address[13:0]};
		end
	end

	read_bus_check: assert property (@(posedge clock) disable iff (reset)
		data_valid == exp_valid && data_out == exp_data)
	else stop_on_mismatch($sformatf("data %h valid %b, expected %h valid %b",
		$sampled(data_out), $sampled(data_valid), $sampled(exp_data), $sampled(exp_valid)));

	sram_addr_check: assert property (@(posedge clock) disable iff (reset)
		sram_addr == exp_sram_addr)
	else stop_on_mismatch($sformatf("sram_addr %h, expected %h",
		$sampled(sram_addr), $sampled(exp_sram_addr)));

	sram_we_check: assert property (@(posedge clock) disable iff (reset)
		sram_we_n == !(mem_sel && !memory_write_n))
	else stop_on_mismatch($sformatf("sram_we_n %b at address %h",
		$sampled(sram_we_n), $sampled(address)));

	lpt_check: assert property (@(posedge clock) disable iff (reset)
		lpt_data == model_lpt)
	else stop_on_mismatch($sformatf("lpt_data %h, expected %h",
		$sampled(lpt_data), $sampled(model_lpt)));

	task automatic stop_on_mismatch(input string msg);
		$display("Error: time %0t: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "output mismatch");
	endtask

	// a bound checker failure ends the run at once
	always @(xt_memory_chipset_inst.xt_memory_chipset_checker_inst.error_count) begin
		if (xt_memory_chipset_inst.xt_memory_chipset_checker_inst.error_count != 0) begin
			$display("SOME TESTS FAILED");
			$fatal(1, "bound checker assertion failed");
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_random();
		seed = xorshift(seed);
		return seed;
	endfunction

	// disable, map and keep codes in about equal shares
	function automatic bus_byte_t random_code();
		logic [31:0] r;
		r = next_random();
		case (r[9:8])
			2'd0: return EMS_DISABLE_CODE;
			2'd1: return {1'b0, r[6:0]};
			2'd2: return ((r[7:0] | 8'h80) == 8'hff) ? 8'hfe : (r[7:0] | 8'h80);
			default: return r[7:0];
		endcase
	endfunction

	function automatic cpu_addr_t ems_port(input ems_slot_t s);
		return {4'h0, EMS_PORT_BASE[15:2], s};
	endfunction

	function automatic cpu_addr_t window_address(input logic [1:0] base_select,
		input ems_slot_t s);
		segment_t seg;
		seg = (base_select == 2'd0) ? EMS_SEGMENT_C :
			(base_select == 2'd1) ? EMS_SEGMENT_D : EMS_SEGMENT_E;
		return {seg, s, 14'(next_random())};
	endfunction

	task automatic bus_cycle(input logic [3:0] strobes_n, input cpu_addr_t addr,
		input bus_byte_t value);
		@(negedge clock);
		{io_read_n, io_write_n, memory_read_n, memory_write_n} = strobes_n;
		address = addr;
		data = value;
		sram_data = bus_byte_t'(next_random());
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) bus_cycle(IDLE, cpu_addr_t'(next_random()), 8'h00);
	endtask

	initial begin
		ems_slot_t s;
		logic [31:0] r;
		reset = 1'b1;
		address = '0;
		data = '0;
		{io_read_n, io_write_n, memory_read_n, memory_write_n} = IDLE;
		address_enable_n = 1'b0;
		ems_enabled = 1'b1;
		ems_base_select = 2'd0;
		sram_data = '0;
		repeat (2) @(negedge clock);
		reset = 1'b0;

		for (int k = 0; k < EMS_SLOTS; k++) begin
			bus_cycle(IO_READ, ems_port(ems_slot_t'(k)), 8'h00);
		end

		// random page writes, some back to back
		repeat (250) begin
			s = ems_slot_t'(next_random());
			bus_cycle(IO_WRITE, ems_port(s), random_code());
			if (next_random() % 3 == 0) begin
				bus_cycle(IO_WRITE, ems_port(s), random_code());
			end
			if (next_random() % 2 == 0) begin
				idle_cycles(1);
			end
			bus_cycle(IO_READ, ems_port(s), 8'h00);
		end

		// window translation under every base select
		repeat (8) begin
			for (int k = 0; k < EMS_SLOTS; k++) begin
				bus_cycle(IO_WRITE, ems_port(ems_slot_t'(k)), random_code());
			end
			idle_cycles(2);
			repeat (40) begin
				r = next_random();
				ems_base_select = r[1:0];
				bus_cycle(r[5] ? MEM_READ : MEM_WRITE,
					r[2] ? window_address(r[1:0], r[4:3]) : cpu_addr_t'(next_random()), r[15:8]);
			end
		end

		repeat (20) begin
			bus_cycle(IO_WRITE, cpu_addr_t'(LPT_PORT), bus_byte_t'(next_random()));
			bus_cycle(IO_READ, cpu_addr_t'(LPT_PORT), 8'h00);
		end

		// EMS ports go deaf while EMS is off
		ems_enabled = 1'b0;
		repeat (20) begin
			s = ems_slot_t'(next_random());
			bus_cycle(IO_WRITE, ems_port(s), random_code());
			idle_cycles(1);
			bus_cycle(IO_READ, ems_port(s), 8'h00);
		end
		idle_cycles(1);
		ems_enabled = 1'b1;
		for (int k = 0; k < EMS_SLOTS; k++) begin
			bus_cycle(IO_READ, ems_port(ems_slot_t'(k)), 8'h00);
		end

		// mixed cycle types with AEN toggling
		repeat (200) begin
			r = next_random();
			address_enable_n = r[0];
			bus_cycle((r[2:1] == 2'd0) ? MEM_WRITE : (r[2:1] == 2'd1) ? IO_WRITE :
				(r[2:1] == 2'd2) ? MEM_READ : IO_READ, cpu_addr_t'(next_random()), r[15:8]);
		end
		address_enable_n = 1'b0;
		idle_cycles(2);

		if (xt_memory_chipset_inst.xt_memory_chipset_checker_inst.error_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "bound checker assertions failed");
		end
	end

endmodule

// File: flist.f
src/xt_bus_pkg.sv
src/io_port_decoder.sv
src/ems_page_registers.sv
src/ems_address_mapper.sv
src/chipset_bus_port.sv
src/xt_memory_chipset.sv
sim/xt_memory_chipset_checker.sv
sim/tb_xt_memory_chipset.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_xt_memory_chipset \
	-f flist.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
